//--- dv/lspcFastCycleTb.sv
`timescale 1ns/1ps

module lspcFastCycleTb;

	import lspcFastPkg::*;

	localparam int spriteCount = 16;
	localparam int listLimit = 8;
	localparam logic [8:0] lineNum = 9'd100;

	// Rough frame budget per test, plus slack
	localparam int testFrames = 30 + 6 + 10 + 110 + 100;
	localparam int timeoutNs = (testFrames + 20) * 32 * 8;

	logic CLK_24M;
	logic TEST;
	logic [8:0] vCount;
	logic chbl;
	logic bFlip;
	logic [10:0] vramMod;
	logic reloadReq;
	logic [10:0] cpuAddr;
	logic [15:0] cpuWrData;
	logic cpuZone;
	logic cpuWrite;
	logic [8:0] attrXPos;
	logic [8:0] renderIdx;
	logic [4:0] tileIdx;
	logic [3:0] tileLine;
	logic [11:0] attrShrink;
	logic [15:0] cpuRdData;
	logic cpuWriteAck;

	logic [31:0] lfsrState;
	logic [15:0] model [int]; // VRAM reference
	logic [10:0] curAddr;
	logic [10:0] curMod;
	logic [15:0] shrinkTab [spriteCount];
	logic [15:0] xTab [spriteCount];
	logic [8:0] yOffTab [spriteCount]; // Line offset each sprite gives
	int matchList [$];

	lspcFastCycle
	#(
		.spriteLimit(spriteCount),
		.listEntries(listLimit)
	)
	lspcFastCycle_inst
	(
		.CLK_24M(CLK_24M),
		.TEST(TEST),
		.vCount(vCount),
		.chbl(chbl),
		.bFlip(bFlip),
		.vramMod(vramMod),
		.reloadReq(reloadReq),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuZone(cpuZone),
		.cpuWrite(cpuWrite),
		.attrXPos(attrXPos),
		.renderIdx(renderIdx),
		.tileIdx(tileIdx),
		.tileLine(tileLine),
		.attrShrink(attrShrink),
		.cpuRdData(cpuRdData),
		.cpuWriteAck(cpuWriteAck)
	);

	always #4 CLK_24M = ~CLK_24M;

	initial
	begin
		repeat (8) @(posedge CLK_24M);
		#1;
		TEST = 1'b0;
	end

	initial
	begin
		#(timeoutNs);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Something failed");
		$fatal(1, "timeout");
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic atCycle(input int n);
		do
			@(negedge CLK_24M);
		while (int'(lspcFastCycle_inst.cycleCount) != n);
	endtask

	task automatic setMod(input logic [10:0] m);
		@(posedge CLK_24M);
		#1;
		vramMod = m;
		curMod = m;
	endtask

	// Reload pulse mid-frame, address held until the next call
	task automatic setAddr(input logic [10:0] a);
		atCycle(19);
		@(posedge CLK_24M);
		#1;
		cpuAddr = a;
		reloadReq = 1'b1;
		@(posedge CLK_24M);
		#1;
		reloadReq = 1'b0;
		curAddr = a;
	endtask

	task automatic writeWord(input logic [15:0] d);
		@(posedge CLK_24M);
		#1;
		cpuWrData = d;
		cpuWrite = 1'b1;
		do
			@(negedge CLK_24M);
		while (cpuWriteAck !== 1'b0);
		@(posedge CLK_24M);
		#1;
		cpuWrite = 1'b0; // Request already taken
		do
			@(negedge CLK_24M);
		while (cpuWriteAck !== 1'b1);
		model[int'(curAddr)] = d;
		curAddr = curAddr + curMod; // 11-bit wrap
	endtask

	task automatic readExpect(input logic [10:0] a, input logic [15:0] exp, input string name);
		setAddr(a);
		atCycle(15);
		checkValue(name, 32'(cpuRdData), 32'(exp));
	endtask

	task automatic readWord(input logic [10:0] a);
		readExpect(a, model[int'(a)], "cpuRdData");
	endtask

	// New line at cycle 13, optionally with a buffer swap
	task automatic startLine(input logic flip);
		atCycle(12);
		@(posedge CLK_24M);
		#1;
		bFlip = flip;
		chbl = 1'b1;
		@(posedge CLK_24M);
		#1;
		chbl = 1'b0;
	endtask

	task automatic checkAttrs(input int idx);
		checkValue("renderIdx", 32'(renderIdx), 32'(idx));
		checkValue("attrShrink", 32'(attrShrink), 32'(shrinkTab[idx][11:0]));
		checkValue("attrXPos", 32'(attrXPos), 32'(xTab[idx][15:7]));
		checkValue("tileIdx", 32'(tileIdx), 32'(yOffTab[idx][8:4]));
		checkValue("tileLine", 32'(tileLine), 32'(yOffTab[idx][3:0]));
	endtask

	task automatic checkResetOutputs();
		checkValue("cpuWriteAck", 32'(cpuWriteAck), 32'd1);
		checkValue("attrXPos", 32'(attrXPos), 32'd0);
		checkValue("renderIdx", 32'(renderIdx), 32'd0);
		checkValue("tileIdx", 32'(tileIdx), 32'd0);
		checkValue("tileLine", 32'(tileLine), 32'd0);
		checkValue("attrShrink", 32'(attrShrink), 32'd0);
		checkValue("cpuRdData", 32'(cpuRdData), 32'd0);
	endtask

	task automatic resetTest();
		repeat (4) @(negedge CLK_24M);
		checkResetOutputs();
		do
			@(negedge CLK_24M);
		while (TEST);
		checkResetOutputs(); // First cycle after release
	endtask

	task automatic cpuWriteTest();
		logic [10:0] base;
		logic [10:0] mod;
		base = 11'(randBits(10)); // Stays clear of the list area
		mod = 11'(randBits(5)) | 11'd1;
		setMod(mod);
		setAddr(base);
		for (int i = 0; i < 8; i++)
			writeWord(16'(randBits(16)));
		for (int i = 0; i < 8; i++)
			readWord(base + 11'(i) * mod);
	endtask

	task automatic stickyReloadTest();
		logic [10:0] a;
		a = 11'h100 + 11'(randBits(8));
		setAddr(a);
		writeWord(16'(randBits(16)));
		readWord(a);
	endtask

	// Write request with the zone inactive must be ignored
	task automatic inactiveZoneTest();
		logic [10:0] a;
		logic [15:0] d;
		a = 11'h100 + 11'(randBits(8));
		d = 16'(randBits(16));
		setAddr(a);
		writeWord(d);
		setAddr(a);
		@(posedge CLK_24M);
		#1;
		cpuZone = 1'b0;
		cpuWrData = ~d;
		cpuWrite = 1'b1;
		for (int f = 0; f < 2; f++)
		begin
			atCycle(13);
			checkValue("cpuWriteAck", 32'(cpuWriteAck), 32'd1);
		end
		@(posedge CLK_24M);
		#1;
		cpuWrite = 1'b0;
		cpuZone = 1'b1;
		readWord(a); // Still the word written with the zone active
	endtask

	// Build a Y word whose line offset against vCount is t
	function automatic logic [15:0] yWord(input logic [8:0] t, input logic [4:0] height);
		logic [8:0] spriteY;
		spriteY = (t ^ 9'h100) - lineNum - 9'd1;
		return {spriteY, 2'(randBits(2)), height};
	endfunction

	task automatic fillYTable(input bit allMatch);
		logic [4:0] height;
		logic [4:0] hi;
		logic [8:0] t;
		matchList.delete();
		setAddr(scb3Base);
		for (int i = 0; i < spriteCount; i++)
		begin
			height = 5'(randBits(5)) | 5'd1;
			if (allMatch || (i % 3 == 0))
			begin
				t = 9'(randBits(9) % (32'(height) * 16));
				matchList.push_back(i);
			end
			else
			begin
				hi = height + 5'(randBits(5) % (32 - 32'(height)));
				t = {hi, 4'(randBits(4))};
			end
			yOffTab[i] = t;
			writeWord(yWord(t, height));
		end
	endtask

	task automatic fillList(input logic buffer, input bit useMarkers);
		setAddr(listBase + {3'd0, buffer, 7'd0});
		for (int i = 0; i <= listLimit; i++)
		begin
			if (useMarkers)
				writeWord(16'(randBits(16)));
			else
				writeWord(16'd0);
		end
	endtask

	task automatic parseRenderTest();
		int idx;
		setMod(11'd1);
		for (int i = 0; i < spriteCount; i++)
		begin
			shrinkTab[i] = 16'(randBits(16));
			xTab[i] = 16'(randBits(16));
		end
		setAddr(scb2Base);
		for (int i = 0; i < spriteCount; i++)
			writeWord(shrinkTab[i]);
		setAddr(scb4Base);
		for (int i = 0; i < spriteCount; i++)
			writeWord(xTab[i]);
		fillYTable(1'b0);
		fillList(1'b0, 1'b0);
		fillList(1'b1, 1'b0);
		startLine(1'b0);
		repeat (8) atCycle(0); // Scan fits in 5 frames
		startLine(1'b1);
		for (int f = 0; f <= listLimit + 1; f++)
		begin
			atCycle(12);
			idx = (f < matchList.size()) ? matchList[f] : 0;
			checkAttrs(idx);
		end
	endtask

	task automatic listCapacityTest();
		fillYTable(1'b1);
		setAddr(listBase);
		for (int i = 0; i < listLimit; i++)
			writeWord(16'd0);
		writeWord(16'(randBits(16))); // Entry past the limit
		fillList(1'b1, 1'b1);
		startLine(1'b1); // Parser fills buffer 0
		repeat (8) atCycle(0);
		for (int i = 0; i < listLimit; i++)
			readExpect(listBase + 11'(i), 16'(i), "list entry");
		readWord(listBase + 11'(listLimit));
		for (int i = 0; i <= listLimit; i++)
			readWord(listBase + 11'd128 + 11'(i));
		startLine(1'b0);
		for (int f = 0; f < listLimit; f++)
		begin
			atCycle(12);
			checkAttrs(f);
		end
	endtask

	initial
	begin
		CLK_24M = 1'b0;
		TEST = 1'b1;
		vCount = lineNum;
		chbl = 1'b0;
		bFlip = 1'b0;
		vramMod = 11'd0;
		reloadReq = 1'b0;
		cpuAddr = 11'd0;
		cpuWrData = 16'd0;
		cpuZone = 1'b1;
		cpuWrite = 1'b0;
		lfsrState = 32'h713a_0c76;
		curAddr = 11'd0;
		curMod = 11'd0;

		resetTest();
		cpuWriteTest();
		stickyReloadTest();
		inactiveZoneTest();
		parseRenderTest();
		listCapacityTest();

		$display("Everything OK");
		$finish;
	end

endmodule

//--- dv/lspcFastCycle_asserts.sv
`timescale 1ns/1ps

module lspcFastCycleAsserts
(
	input logic CLK_24M,
	input logic TEST,
	input logic [4:0] cycleCount,
	input logic vramWe,
	input logic cpuZone,
	input logic cpuWriteAck
);

	import lspcFastPkg::*;

	// Render windows are read only
	noWriteInRender: assert property (@(posedge CLK_24M) disable iff (TEST)
		(cycleCount < 5'(cpuSlotStart)) |-> !vramWe)
		else $error("VRAM write strobe inside a render window");

	frameWrap: assert property (@(posedge CLK_24M) disable iff (TEST)
		(cycleCount == 5'd31) |=> (cycleCount == 5'd0))
		else $error("Frame counter did not wrap to 0");

	ackOutsideZone: assert property (@(posedge CLK_24M) disable iff (TEST)
		!cpuZone |-> cpuWriteAck)
		else $error("Write acknowledge low while CPU zone is inactive");

endmodule

bind lspcFastCycle lspcFastCycleAsserts asserts_inst
(
	.CLK_24M(CLK_24M),
	.TEST(TEST),
	.cycleCount(cycleCount),
	.vramWe(vramWe),
	.cpuZone(cpuZone),
	.cpuWriteAck(cpuWriteAck)
);

//--- lspcFastCycle.f
rtl/lspcFastPkg.sv
rtl/fastVram.sv
rtl/fastSlotTimer.sv
rtl/spriteParser.sv
rtl/renderFetch.sv
rtl/cpuVramPort.sv
rtl/lspcFastCycle.sv
dv/lspcFastCycle_asserts.sv
dv/lspcFastCycleTb.sv

//--- rtl/cpuVramPort.sv
`timescale 1ns/1ps

module cpuVramPort
(
	input logic CLK_24M,
	input logic TEST,
	input logic [lspcFastPkg::addrWidth-1:0] cpuAddr,
	input logic [lspcFastPkg::dataWidth-1:0] cpuWrData,
	input logic cpuZone,
	input logic cpuWrite,
	input logic reloadReq,
	input logic [lspcFastPkg::addrWidth-1:0] vramMod,
	input logic [4:0] cycleCount,
	input logic [lspcFastPkg::dataWidth-1:0] rdData,
	output logic [lspcFastPkg::addrWidth-1:0] cpuVramAddr,
	output logic [lspcFastPkg::dataWidth-1:0] cpuVramWrData,
	output logic cpuWe,
	output logic [lspcFastPkg::dataWidth-1:0] cpuRdData,
	output logic cpuWriteAck
);

	import lspcFastPkg::*;

	logic reloadFlag;
	logic writePending;
	logic requestCycle;
	logic captureCycle;

	assign requestCycle = (cycleCount == scb4SlotStart + 1); // Cycle 11
	assign captureCycle = (cycleCount == cpuSlotStart + 1); // Cycle 14

	assign cpuWe = writePending && (cycleCount == cpuSlotStart);
	assign cpuWriteAck = ~writePending | ~cpuZone;

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			reloadFlag <= 1'b0;
			writePending <= 1'b0;
			cpuVramAddr <= '0;
			cpuRdData <= '0;
		end
		else
		begin
			if (reloadReq)
				reloadFlag <= 1'b1; // Sticky until the next request cycle
			else if (requestCycle)
				reloadFlag <= 1'b0;

			if (requestCycle)
			begin
				if (reloadFlag)
					cpuVramAddr <= cpuAddr;
				writePending <= cpuWrite & cpuZone;
			end

			if (captureCycle)
			begin
				cpuRdData <= rdData;
				if (writePending)
					cpuVramAddr <= cpuVramAddr + vramMod; // 11-bit wrap
				writePending <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK_24M)
	begin
		if (requestCycle)
			cpuVramWrData <= cpuWrData;
	end

endmodule

//--- rtl/fastSlotTimer.sv
`timescale 1ns/1ps

module fastSlotTimer
(
	input logic CLK_24M,
	input logic TEST,
	input logic [lspcFastPkg::addrWidth-1:0] renderAddr,
	input logic [lspcFastPkg::addrWidth-1:0] cpuVramAddr,
	input logic [lspcFastPkg::dataWidth-1:0] cpuVramWrData,
	input logic cpuWe,
	input logic [lspcFastPkg::addrWidth-1:0] parseAddr,
	input logic [lspcFastPkg::dataWidth-1:0] parseWrData,
	input logic parseWe,
	output logic [4:0] cycleCount,
	output lspcFastPkg::slotKind slot,
	output logic [lspcFastPkg::addrWidth-1:0] vramAddr,
	output logic [lspcFastPkg::dataWidth-1:0] vramWrData,
	output logic vramWe
);

	import lspcFastPkg::*;

	localparam int parseSlotEnd = parseSlotStart + parseSlotLength * parseSlotCount;

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
			cycleCount <= 5'd0;
		else
			cycleCount <= cycleCount + 5'd1; // Wraps after 31
	end

	always_comb
	begin
		if (cycleCount < scb2SlotStart)
			slot = listRead;
		else if (cycleCount < scb3SlotStart)
			slot = scb2Read;
		else if (cycleCount < scb4SlotStart)
			slot = scb3Read;
		else if (cycleCount < cpuSlotStart)
			slot = scb4Read;
		else if (cycleCount < parseSlotStart)
			slot = cpuAccess;
		else if (cycleCount < parseSlotEnd)
			slot = parseAccess;
		else
			slot = idle;
	end

	// Single RAM port shared by slot owner
	always_comb
	begin
		case (slot)
			listRead, scb2Read, scb3Read, scb4Read:
			begin
				vramAddr = renderAddr;
				vramWrData = parseWrData;
				vramWe = 1'b0;
			end
			cpuAccess:
			begin
				vramAddr = cpuVramAddr;
				vramWrData = cpuVramWrData;
				vramWe = cpuWe;
			end
			parseAccess:
			begin
				vramAddr = parseAddr;
				vramWrData = parseWrData;
				vramWe = parseWe;
			end
			default:
			begin
				vramAddr = parseAddr;
				vramWrData = parseWrData;
				vramWe = 1'b0; // Idle cycle
			end
		endcase
	end

endmodule

//--- rtl/fastVram.sv
`timescale 1ns/1ps

module fastVram
(
	input logic CLK_24M,
	input logic [lspcFastPkg::addrWidth-1:0] addr,
	input logic [lspcFastPkg::dataWidth-1:0] wrData,
	input logic we,
	output logic [lspcFastPkg::dataWidth-1:0] rdData
);

	import lspcFastPkg::*;

	logic [dataWidth-1:0] mem [2**addrWidth];

	// Read returns the old word when written in the same cycle
	always_ff @(posedge CLK_24M)
	begin
		if (we)
		begin
			mem[addr] <= wrData;
		end
		rdData <= mem[addr];
	end

endmodule

//--- rtl/lspcFastCycle.sv
`timescale 1ns/1ps

module lspcFastCycle
#(
	parameter int spriteLimit = 64,
	parameter int listEntries = 96
)
(
	input logic CLK_24M,
	input logic TEST,
	input logic [8:0] vCount,
	input logic chbl,
	input logic bFlip,
	input logic [lspcFastPkg::addrWidth-1:0] vramMod,
	input logic reloadReq,
	input logic [lspcFastPkg::addrWidth-1:0] cpuAddr,
	input logic [lspcFastPkg::dataWidth-1:0] cpuWrData,
	input logic cpuZone,
	input logic cpuWrite,
	output logic [8:0] attrXPos,
	output logic [lspcFastPkg::spriteNumWidth-1:0] renderIdx,
	output logic [4:0] tileIdx,
	output logic [3:0] tileLine,
	output logic [11:0] attrShrink,
	output logic [lspcFastPkg::dataWidth-1:0] cpuRdData,
	output logic cpuWriteAck
);

	import lspcFastPkg::*;

	logic [4:0] cycleCount;
	slotKind slot;

	// RAM port
	logic [addrWidth-1:0] vramAddr;
	logic [dataWidth-1:0] vramWrData;
	logic vramWe;
	logic [dataWidth-1:0] rdData;

	// Requester offers
	logic [addrWidth-1:0] renderAddr;
	logic [addrWidth-1:0] cpuVramAddr;
	logic [dataWidth-1:0] cpuVramWrData;
	logic cpuWe;
	logic [addrWidth-1:0] parseAddr;
	logic [dataWidth-1:0] parseWrData;
	logic parseWe;

	fastSlotTimer fastSlotTimer_inst
	(
		.CLK_24M(CLK_24M),
		.TEST(TEST),
		.renderAddr(renderAddr),
		.cpuVramAddr(cpuVramAddr),
		.cpuVramWrData(cpuVramWrData),
		.cpuWe(cpuWe),
		.parseAddr(parseAddr),
		.parseWrData(parseWrData),
		.parseWe(parseWe),
		.cycleCount(cycleCount),
		.slot(slot),
		.vramAddr(vramAddr),
		.vramWrData(vramWrData),
		.vramWe(vramWe)
	);

	fastVram fastVram_inst
	(
		.CLK_24M(CLK_24M),
		.addr(vramAddr),
		.wrData(vramWrData),
		.we(vramWe),
		.rdData(rdData)
	);

	spriteParser
	#(
		.spriteLimit(spriteLimit),
		.listEntries(listEntries)
	)
	spriteParser_inst
	(
		.CLK_24M(CLK_24M),
		.TEST(TEST),
		.chbl(chbl),
		.bFlip(bFlip),
		.vCount(vCount),
		.cycleCount(cycleCount),
		.slot(slot),
		.rdData(rdData),
		.parseAddr(parseAddr),
		.parseWrData(parseWrData),
		.parseWe(parseWe)
	);

	// Sticky bit goes to the pixel pipeline outside this block
	renderFetch
	#(
		.listEntries(listEntries)
	)
	renderFetch_inst
	(
		.CLK_24M(CLK_24M),
		.TEST(TEST),
		.chbl(chbl),
		.bFlip(bFlip),
		.vCount(vCount),
		.cycleCount(cycleCount),
		.rdData(rdData),
		.renderAddr(renderAddr),
		.renderIdx(renderIdx),
		.attrShrink(attrShrink),
		.tileIdx(tileIdx),
		.tileLine(tileLine),
		.attrSticky(),
		.attrXPos(attrXPos)
	);

	cpuVramPort cpuVramPort_inst
	(
		.CLK_24M(CLK_24M),
		.TEST(TEST),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuZone(cpuZone),
		.cpuWrite(cpuWrite),
		.reloadReq(reloadReq),
		.vramMod(vramMod),
		.cycleCount(cycleCount),
		.rdData(rdData),
		.cpuVramAddr(cpuVramAddr),
		.cpuVramWrData(cpuVramWrData),
		.cpuWe(cpuWe),
		.cpuRdData(cpuRdData),
		.cpuWriteAck(cpuWriteAck)
	);

endmodule

//--- rtl/lspcFastPkg.sv
package lspcFastPkg;

	// VRAM geometry
	localparam int addrWidth = 11;
	localparam int dataWidth = 16;
	localparam int spriteNumWidth = 9;

	// Frame slot windows, in cycles of CLK_24M
	localparam int listSlotStart = 0;
	localparam int scb2SlotStart = 4;
	localparam int scb3SlotStart = 7;
	localparam int scb4SlotStart = 10;
	localparam int cpuSlotStart = 13;
	localparam int parseSlotStart = 16;
	localparam int parseSlotLength = 3;
	localparam int parseSlotCount = 5;

	// Table bases in fast VRAM
	localparam logic [addrWidth-1:0] scb2Base = 11'h000; // Shrink
	localparam logic [addrWidth-1:0] scb3Base = 11'h200; // Y, sticky, height
	localparam logic [addrWidth-1:0] scb4Base = 11'h400; // X
	localparam logic [addrWidth-1:0] listBase = 11'h600; // Two 128-entry lists

	typedef enum logic [2:0]
	{
		listRead,
		scb2Read,
		scb3Read,
		scb4Read,
		cpuAccess,
		parseAccess,
		idle
	} slotKind;

	// Line offset inside a sprite, shared by parser and render fetch
	function automatic logic [8:0] lineOffset(input logic [8:0] spriteY, input logic [8:0] vCount);
		return (spriteY + vCount + 9'd1) ^ 9'h100;
	endfunction

endpackage

//--- rtl/renderFetch.sv
`timescale 1ns/1ps

module renderFetch
#(
	parameter int listEntries = 96
)
(
	input logic CLK_24M,
	input logic TEST,
	input logic chbl,
	input logic bFlip,
	input logic [8:0] vCount,
	input logic [4:0] cycleCount,
	input logic [lspcFastPkg::dataWidth-1:0] rdData,
	output logic [lspcFastPkg::addrWidth-1:0] renderAddr,
	output logic [lspcFastPkg::spriteNumWidth-1:0] renderIdx,
	output logic [11:0] attrShrink,
	output logic [4:0] tileIdx,
	output logic [3:0] tileLine,
	output logic attrSticky,
	output logic [8:0] attrXPos
);

	import lspcFastPkg::*;

	logic [7:0] readCount;
	logic [spriteNumWidth-1:0] fetchIdx;
	logic [11:0] shrinkStage;
	logic stickyStage;
	logic [8:0] yStage;
	logic [8:0] yAdded;
	logic listCapture;
	logic shrinkCapture;
	logic yCapture;
	logic xCapture;

	assign listCapture = (cycleCount == listSlotStart + 2);
	assign shrinkCapture = (cycleCount == scb2SlotStart + 1);
	assign yCapture = (cycleCount == scb3SlotStart + 1);
	assign xCapture = (cycleCount == scb4SlotStart + 1);

	assign yAdded = lineOffset(rdData[15:7], vCount);

	always_comb
	begin
		if (cycleCount < scb2SlotStart)
			renderAddr = listBase + addrWidth'({bFlip, readCount[6:0]});
		else if (cycleCount < scb3SlotStart)
			renderAddr = scb2Base + addrWidth'(fetchIdx);
		else if (cycleCount < scb4SlotStart)
			renderAddr = scb3Base + addrWidth'(fetchIdx);
		else
			renderAddr = scb4Base + addrWidth'(fetchIdx);
	end

	// Staging during the frame, outputs move together at the X capture
	always_ff @(posedge CLK_24M)
	begin
		if (listCapture)
			fetchIdx <= rdData[spriteNumWidth-1:0];
		if (shrinkCapture)
			shrinkStage <= rdData[11:0];
		if (yCapture)
		begin
			stickyStage <= rdData[6];
			yStage <= yAdded;
		end
	end

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			readCount <= 8'd0;
			renderIdx <= '0;
			attrShrink <= 12'd0;
			tileIdx <= 5'd0;
			tileLine <= 4'd0;
			attrSticky <= 1'b0;
			attrXPos <= 9'd0;
		end
		else
		begin
			if (xCapture)
			begin
				renderIdx <= fetchIdx;
				attrShrink <= shrinkStage;
				attrSticky <= stickyStage;
				tileIdx <= yStage[8:4];
				tileLine <= yStage[3:0];
				attrXPos <= rdData[15:7];
			end
			if (chbl)
				readCount <= 8'd0;
			else if (xCapture && (readCount < listEntries))
				readCount <= readCount + 8'd1; // Stops at list end
		end
	end

endmodule

//--- rtl/spriteParser.sv
`timescale 1ns/1ps

module spriteParser
#(
	parameter int spriteLimit = 64,
	parameter int listEntries = 96
)
(
	input logic CLK_24M,
	input logic TEST,
	input logic chbl,
	input logic bFlip,
	input logic [8:0] vCount,
	input logic [4:0] cycleCount,
	input lspcFastPkg::slotKind slot,
	input logic [lspcFastPkg::dataWidth-1:0] rdData,
	output logic [lspcFastPkg::addrWidth-1:0] parseAddr,
	output logic [lspcFastPkg::dataWidth-1:0] parseWrData,
	output logic parseWe
);

	import lspcFastPkg::*;

	logic [9:0] parseCounter; // Next sprite to test
	logic [7:0] writeCount; // List fill level
	logic pending;
	logic [spriteNumWidth-1:0] pendingNum;

	logic [4:0] slotOffset;
	logic inParse;
	logic firstCycle;
	logic lastCycle;
	logic listFull;
	logic scanning;
	logic writeMode;
	logic [8:0] yAdded;
	logic yMatch;

	assign inParse = (slot == parseAccess);
	assign slotOffset = cycleCount - 5'(parseSlotStart);
	assign firstCycle = inParse && ((slotOffset % parseSlotLength) == 0);
	assign lastCycle = inParse && ((slotOffset % parseSlotLength) == parseSlotLength - 1);

	assign listFull = (writeCount >= listEntries);
	assign scanning = (parseCounter < spriteLimit);

	// Mode holds for a whole slot since state only moves at its last cycle
	assign writeMode = pending && !listFull;

	assign yAdded = lineOffset(rdData[15:7], vCount);
	assign yMatch = (yAdded[8:4] < rdData[4:0]);

	always_comb
	begin
		if (writeMode)
			parseAddr = listBase + addrWidth'({~bFlip, writeCount[6:0]});
		else
			parseAddr = scb3Base + addrWidth'(parseCounter[8:0]);
	end

	assign parseWrData = {{(dataWidth - spriteNumWidth){1'b0}}, pendingNum};
	assign parseWe = firstCycle && writeMode;

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			parseCounter <= 10'd0;
			writeCount <= 8'd0;
			pending <= 1'b0;
		end
		else if (chbl)
		begin
			// New line, start a fresh scan
			parseCounter <= 10'd0;
			writeCount <= 8'd0;
			pending <= 1'b0;
		end
		else if (lastCycle)
		begin
			if (writeMode)
			begin
				pending <= 1'b0;
				writeCount <= writeCount + 8'd1;
			end
			else if (scanning)
			begin
				if (yMatch)
					pending <= 1'b1;
				parseCounter <= parseCounter + 10'd1;
			end
		end
	end

	// Sprite number of the match waiting for a list write
	always_ff @(posedge CLK_24M)
	begin
		if (lastCycle && !writeMode && scanning && yMatch)
			pendingNum <= parseCounter[8:0];
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lspcFastCycleTb \
	-f lspcFastCycle.f --Mdir obj_dir -o simv > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && exit 1 || exit 0
